//--- Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= tb_axil_mbox
FILELIST ?= list.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- axil_mbox/axil_mbox_ctrl.sv
`timescale 1ns/1ps
`include "mbox_params.svh"

module axil_mbox_ctrl (
  input  logic                   clk,
  input  logic                   arst,
  input  mbox_pkg::axil_wr_req_t wr_req_i,
  output mbox_pkg::axil_wr_rsp_t wr_rsp_o,
  input  mbox_pkg::axil_rd_req_t rd_req_i,
  output mbox_pkg::axil_rd_rsp_t rd_rsp_o,
  output logic                   tx_push_o,
  output mbox_pkg::mbox_word_t   tx_data_o,
  input  logic                   tx_err_i,
  output logic                   rx_pop_o,
  input  mbox_pkg::mbox_word_t   rx_data_i,
  input  logic                   rx_err_i,
  output logic                   ctrl_we_o,
  output mbox_pkg::mbox_word_t   ctrl_wdata_o,
  input  mbox_pkg::mbox_status_t status_i
);

  localparam int STATUS_W = $bits(mbox_pkg::mbox_status_t);

  mbox_pkg::ctrl_state_e state_q;   // Current bus state.
  mbox_pkg::ctrl_state_e state_d;
  logic                  rd_accept; // Read address taken this cycle.
  logic                  wr_accept; // Write address and data taken this cycle.
  mbox_pkg::mbox_word_t  rdata_d;   // Read data selected by address.
  mbox_pkg::mbox_word_t  rdata_q;
  mbox_pkg::axil_resp_t  bresp_q;
  mbox_pkg::axil_resp_t  rresp_q;

  // ########################################
  // Acceptance and decode
  // ########################################
  // Reads win when both arrive in the same idle cycle.
  assign rd_accept = (state_q == mbox_pkg::ST_IDLE) && rd_req_i.arvalid;
  assign wr_accept = (state_q == mbox_pkg::ST_IDLE) && !rd_req_i.arvalid &&
                     wr_req_i.awvalid && wr_req_i.wvalid;  // Address and data together.

  assign tx_push_o    = wr_accept && (wr_req_i.awaddr == `MBOX_REG_TX);   // One-cycle push.
  assign tx_data_o    = wr_req_i.wdata;
  assign ctrl_we_o    = wr_accept && (wr_req_i.awaddr == `MBOX_REG_CTRL); // Control write.
  assign ctrl_wdata_o = wr_req_i.wdata;
  assign rx_pop_o     = rd_accept && (rd_req_i.araddr == `MBOX_REG_RX);   // One-cycle pop.

  always_comb begin
    case (rd_req_i.araddr)
      `MBOX_REG_RX: begin
        rdata_d = rx_data_i;  // Head of receive queue, zero when empty.
      end
      `MBOX_REG_STATUS: begin
        rdata_d = {{(`MBOX_DATA_W-STATUS_W){1'b0}}, status_i};  // Zero-extended.
      end
      `MBOX_REG_CTRL: begin
        rdata_d = {{(`MBOX_DATA_W-1){1'b0}}, status_i.irq_en};  // Enable only.
      end
      default: begin
        rdata_d = '0;  // Transmit register and holes read zero.
      end
    endcase
  end

  // ########################################
  // State machine
  // ########################################
  always_comb begin
    state_d = state_q;
    case (state_q)
      mbox_pkg::ST_IDLE: begin
        if (rd_accept) begin
          state_d = mbox_pkg::ST_RRESP;
        end else if (wr_accept) begin
          state_d = mbox_pkg::ST_BRESP;
        end
      end
      mbox_pkg::ST_BRESP: begin
        if (wr_req_i.bready) begin
          state_d = mbox_pkg::ST_IDLE;  // Response taken.
        end
      end
      mbox_pkg::ST_RRESP: begin
        if (rd_req_i.rready) begin
          state_d = mbox_pkg::ST_IDLE;  // Response taken.
        end
      end
      default: begin
        state_d = mbox_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state_q <= mbox_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Response fields are captured on acceptance and held until the handshake.
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      bresp_q <= (tx_push_o && tx_err_i) ? mbox_pkg::AXIL_SLVERR :
                                           mbox_pkg::AXIL_OKAY;  // Push into full queue.
    end
    if (rd_accept) begin
      rdata_q <= rdata_d;
      rresp_q <= (rx_pop_o && rx_err_i) ? mbox_pkg::AXIL_SLVERR :
                                          mbox_pkg::AXIL_OKAY;   // Pop from empty queue.
    end
  end

  // ########################################
  // Response channels
  // ########################################
  always_comb begin
    wr_rsp_o.awready = wr_accept;
    wr_rsp_o.wready  = wr_accept;
    wr_rsp_o.bresp   = bresp_q;
    wr_rsp_o.bvalid  = (state_q == mbox_pkg::ST_BRESP);
    rd_rsp_o.arready = rd_accept;
    rd_rsp_o.rdata   = rdata_q;
    rd_rsp_o.rresp   = rresp_q;
    rd_rsp_o.rvalid  = (state_q == mbox_pkg::ST_RRESP);
  end

endmodule

//--- axil_mbox/mbox_status.sv
`timescale 1ns/1ps
`include "mbox_params.svh"

module mbox_status (
  input  logic                   clk,
  input  logic                   arst,
  input  logic                   tx_err_i,
  input  logic                   rx_err_i,
  input  logic                   tx_empty_i,
  input  logic                   tx_full_i,
  input  logic                   rx_empty_i,
  input  logic                   rx_full_i,
  input  logic                   ctrl_we_i,
  input  mbox_pkg::mbox_word_t   ctrl_wdata_i,
  output mbox_pkg::mbox_status_t status_o,
  output logic                   irq_o
);

  logic irq_en_q;  // Interrupt enable.
  logic tx_ovf_q;  // Sticky host overflow.
  logic rx_unf_q;  // Sticky host underflow.
  logic clr_req;   // Clear request from a control write.

  assign clr_req = ctrl_we_i && ctrl_wdata_i[`MBOX_CTRL_CLR];

  // ########################################
  // Enable and sticky flags
  // ########################################
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      irq_en_q <= 1'b0;
      tx_ovf_q <= 1'b0;
      rx_unf_q <= 1'b0;
    end else begin
      if (ctrl_we_i) begin
        irq_en_q <= ctrl_wdata_i[`MBOX_CTRL_IRQ_EN];  // Every control write sets it.
      end
      // A new error beats a clear on the same edge.
      if (tx_err_i) begin
        tx_ovf_q <= 1'b1;
      end else if (clr_req) begin
        tx_ovf_q <= 1'b0;
      end
      if (rx_err_i) begin
        rx_unf_q <= 1'b1;
      end else if (clr_req) begin
        rx_unf_q <= 1'b0;
      end
    end
  end

  // ########################################
  // Status word and interrupt
  // ########################################
  always_comb begin
    status_o.tx_empty     = tx_empty_i;
    status_o.tx_full      = tx_full_i;
    status_o.rx_empty     = rx_empty_i;
    status_o.rx_full      = rx_full_i;
    status_o.tx_overflow  = tx_ovf_q;
    status_o.rx_underflow = rx_unf_q;
    status_o.irq_en       = irq_en_q;
  end

  assign irq_o = irq_en_q && !rx_empty_i;  // Level interrupt while words wait.

endmodule

//--- common/mbox_params.svh
`ifndef MBOX_PARAMS_SVH
`define MBOX_PARAMS_SVH

// ########################################
// Widths and queue depths
// ########################################
`define MBOX_DATA_W     32    // Mailbox word and AXI data bus.
`define MBOX_ADDR_W     4     // Register address.
`define MBOX_TX_SLOTS   4     // Transmit queue depth in words.
`define MBOX_RX_SLOTS   4     // Receive queue depth in words.

// ########################################
// Register map
// ########################################
`define MBOX_REG_TX     4'h0  // Write pushes a word.
`define MBOX_REG_RX     4'h4  // Read pops a word.
`define MBOX_REG_STATUS 4'h8  // Read-only status word.
`define MBOX_REG_CTRL   4'hC  // Interrupt enable and error clear.

`define MBOX_CTRL_IRQ_EN 0    // Interrupt enable bit of the control register.
`define MBOX_CTRL_CLR    1    // Sticky error clear bit of the control register.

`endif

//--- common/mbox_pkg.sv
`include "mbox_params.svh"

package mbox_pkg;

  typedef logic [`MBOX_DATA_W-1:0] mbox_word_t;  // One mailbox word.
  typedef logic [`MBOX_ADDR_W-1:0] axil_addr_t;  // Register address.
  typedef logic [1:0]              axil_resp_t;  // AXI response code.

  localparam axil_resp_t AXIL_OKAY   = 2'b00;    // Normal access.
  localparam axil_resp_t AXIL_SLVERR = 2'b10;    // Queue misuse.

  // ########################################
  // AXI4-Lite channels
  // ########################################
  typedef struct packed {
    axil_addr_t awaddr;
    logic       awvalid;
    mbox_word_t wdata;
    logic       wvalid;
    logic       bready;
  } axil_wr_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    axil_resp_t bresp;
    logic       bvalid;
  } axil_wr_rsp_t;

  typedef struct packed {
    axil_addr_t araddr;
    logic       arvalid;
    logic       rready;
  } axil_rd_req_t;

  typedef struct packed {
    logic       arready;
    mbox_word_t rdata;
    axil_resp_t rresp;
    logic       rvalid;
  } axil_rd_rsp_t;

  // Status word fields, highest bit first.
  typedef struct packed {
    logic irq_en;        // Bit 6.
    logic rx_underflow;  // Bit 5, sticky.
    logic tx_overflow;   // Bit 4, sticky.
    logic rx_full;
    logic rx_empty;
    logic tx_full;
    logic tx_empty;      // Bit 0.
  } mbox_status_t;

  typedef enum logic [1:0] {
    ST_IDLE,   // Waiting for a request.
    ST_BRESP,  // Write response pending.
    ST_RRESP   // Read response pending.
  } ctrl_state_e;

endpackage

//--- list.f
+incdir+common
common/mbox_pkg.sv
rtl/fifo.sv
axil_mbox/axil_mbox_ctrl.sv
axil_mbox/mbox_status.sv
rtl/axil_mbox_top.sv
verification/axil_mbox_asserts.sv
verification/tb_axil_mbox.sv

//--- rtl/axil_mbox_top.sv
`timescale 1ns/1ps
`include "mbox_params.svh"

module axil_mbox_top (
  input  logic                   clk,
  input  logic                   arst,
  input  mbox_pkg::axil_wr_req_t wr_req_i,
  output mbox_pkg::axil_wr_rsp_t wr_rsp_o,
  input  mbox_pkg::axil_rd_req_t rd_req_i,
  output mbox_pkg::axil_rd_rsp_t rd_rsp_o,
  output mbox_pkg::mbox_word_t   m_data_o,
  output logic                   m_valid_o,
  input  logic                   m_ready_i,
  input  mbox_pkg::mbox_word_t   s_data_i,
  input  logic                   s_valid_i,
  output logic                   s_ready_o,
  output logic                   irq_o
);

  logic                   tx_push;     // Host write into transmit queue.
  mbox_pkg::mbox_word_t   tx_data;
  logic                   tx_pop;      // Outgoing stream transfer.
  logic                   tx_err;
  logic                   tx_full;
  logic                   tx_empty;
  logic                   rx_push;     // Incoming stream transfer.
  logic                   rx_pop;      // Host read from receive queue.
  mbox_pkg::mbox_word_t   rx_data;
  logic                   rx_err;
  logic                   rx_full;
  logic                   rx_empty;
  logic                   ctrl_we;
  mbox_pkg::mbox_word_t   ctrl_wdata;
  mbox_pkg::mbox_status_t status;

  // ########################################
  // Stream handshakes
  // ########################################
  assign m_valid_o = !tx_empty;              // Offer the head word.
  assign tx_pop    = m_valid_o && m_ready_i;
  assign s_ready_o = !rx_full;               // Accept while there is room.
  assign rx_push   = s_valid_i && s_ready_o;

  axil_mbox_ctrl u_ctrl (
    .clk          (clk),
    .arst         (arst),
    .wr_req_i     (wr_req_i),
    .wr_rsp_o     (wr_rsp_o),
    .rd_req_i     (rd_req_i),
    .rd_rsp_o     (rd_rsp_o),
    .tx_push_o    (tx_push),
    .tx_data_o    (tx_data),
    .tx_err_i     (tx_err),
    .rx_pop_o     (rx_pop),
    .rx_data_i    (rx_data),
    .rx_err_i     (rx_err),
    .ctrl_we_o    (ctrl_we),
    .ctrl_wdata_o (ctrl_wdata),
    .status_i     (status)
  );

  fifo #(.SLOTS(`MBOX_TX_SLOTS), .WIDTH(`MBOX_DATA_W)) u_tx_fifo (
    .clk     (clk),
    .arst    (arst),
    .write_i (tx_push),
    .read_i  (tx_pop),
    .data_i  (tx_data),
    .data_o  (m_data_o),
    .error_o (tx_err),   // Host overflow only.
    .full_o  (tx_full),
    .empty_o (tx_empty)
  );

  fifo #(.SLOTS(`MBOX_RX_SLOTS), .WIDTH(`MBOX_DATA_W)) u_rx_fifo (
    .clk     (clk),
    .arst    (arst),
    .write_i (rx_push),
    .read_i  (rx_pop),
    .data_i  (s_data_i),
    .data_o  (rx_data),
    .error_o (rx_err),   // Host underflow only.
    .full_o  (rx_full),
    .empty_o (rx_empty)
  );

  mbox_status u_status (
    .clk          (clk),
    .arst         (arst),
    .tx_err_i     (tx_err),
    .rx_err_i     (rx_err),
    .tx_empty_i   (tx_empty),
    .tx_full_i    (tx_full),
    .rx_empty_i   (rx_empty),
    .rx_full_i    (rx_full),
    .ctrl_we_i    (ctrl_we),
    .ctrl_wdata_i (ctrl_wdata),
    .status_o     (status),
    .irq_o        (irq_o)
  );

endmodule

//--- rtl/fifo.sv
`timescale 1ns/1ps

module fifo #(
  parameter int SLOTS = 2,
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             arst,
  input  logic             write_i,
  input  logic             read_i,
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o,
  output logic             error_o,
  output logic             full_o,
  output logic             empty_o
);

  localparam int IDX_W = $clog2(SLOTS);  // Index bits, pointers get one more.

  logic [WIDTH-1:0] mem_q [SLOTS];        // Queue storage.
  logic [IDX_W:0]   wr_ptr_q;             // Write pointer with wrap bit.
  logic [IDX_W:0]   rd_ptr_q;             // Read pointer with wrap bit.
  logic             do_write;
  logic             do_read;

  // Depth must be a power of two so the pointers wrap cleanly.
  if ((SLOTS < 2) || ((1 << IDX_W) != SLOTS)) begin : g_slots_check
    $error("fifo: SLOTS must be a power of two and at least 2");
  end

  // ########################################
  // Flags and output word
  // ########################################
  assign empty_o = (wr_ptr_q == rd_ptr_q);                     // Same lap, same slot.
  assign full_o  = (wr_ptr_q[IDX_W-1:0] == rd_ptr_q[IDX_W-1:0]) &&
                   (wr_ptr_q[IDX_W] != rd_ptr_q[IDX_W]);       // One lap ahead.
  assign data_o  = empty_o ? '0 : mem_q[rd_ptr_q[IDX_W-1:0]]; // Head word, zero when empty.

  assign do_write = write_i && !full_o;   // Writes to a full queue are dropped.
  assign do_read  = read_i && !empty_o;   // Reads of an empty queue are dropped.
  assign error_o  = (write_i && full_o) ||
                    (read_i && empty_o);  // Misuse pulse, same cycle.

  // ########################################
  // Pointers and storage
  // ########################################
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_write) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // Advance past the new word.
      end
      if (do_read) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;  // Release the head slot.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem_q[wr_ptr_q[IDX_W-1:0]] <= data_i;  // Store at the tail.
    end
  end

endmodule

//--- verification/axil_mbox_asserts.sv
`timescale 1ns/1ps

module axil_mbox_asserts (
  input logic                   clk,
  input logic                   arst,
  input mbox_pkg::axil_wr_req_t wr_req_i,
  input mbox_pkg::axil_wr_rsp_t wr_rsp_i,
  input mbox_pkg::axil_rd_req_t rd_req_i,
  input mbox_pkg::axil_rd_rsp_t rd_rsp_i,
  input mbox_pkg::mbox_word_t   m_data_i,
  input logic                   m_valid_i,
  input logic                   m_ready_i
);

  // ########################################
  // Host bus responses
  // ########################################
  a_bvalid_hold: assert property (
    @(posedge clk) disable iff (arst)
    wr_rsp_i.bvalid && !wr_req_i.bready |=> wr_rsp_i.bvalid && $stable(wr_rsp_i.bresp)
  ) else $error("bvalid or bresp changed before bready");

  a_rvalid_hold: assert property (
    @(posedge clk) disable iff (arst)
    rd_rsp_i.rvalid && !rd_req_i.rready |=> rd_rsp_i.rvalid && $stable(rd_rsp_i.rdata)
  ) else $error("rvalid or rdata changed before rready");

  a_one_response: assert property (
    @(posedge clk) disable iff (arst)
    !(wr_rsp_i.bvalid && rd_rsp_i.rvalid)  // One transaction at a time.
  ) else $error("bvalid and rvalid high together");

  // ########################################
  // Outgoing stream
  // ########################################
  a_m_valid_hold: assert property (
    @(posedge clk) disable iff (arst)
    m_valid_i && !m_ready_i |=> m_valid_i && $stable(m_data_i)
  ) else $error("m_valid_o dropped before the transfer");

endmodule

//--- verification/tb_axil_mbox.sv
`timescale 1ns/1ps
`include "mbox_params.svh"

module tb_axil_mbox;

  localparam int TIMEOUT  = 64;                             // Cycles allowed per wait.
  localparam int STATUS_W = $bits(mbox_pkg::mbox_status_t);

  logic                   clk;
  logic                   arst;
  mbox_pkg::axil_wr_req_t wr_req;
  mbox_pkg::axil_wr_rsp_t wr_rsp;
  mbox_pkg::axil_rd_req_t rd_req;
  mbox_pkg::axil_rd_rsp_t rd_rsp;
  mbox_pkg::mbox_word_t   m_data;
  logic                   m_valid;
  logic                   m_ready;
  mbox_pkg::mbox_word_t   s_data;
  logic                   s_valid;
  logic                   s_ready;
  logic                   irq;
  logic [15:0]            lfsr_q;        // Galois LFSR state.
  int                     value_errors;  // Wrong values seen.
  int                     other_errors;  // Stalls and timeouts.
  int                     checks;

  axil_mbox_top u_dut (
    .clk       (clk),
    .arst      (arst),
    .wr_req_i  (wr_req),
    .wr_rsp_o  (wr_rsp),
    .rd_req_i  (rd_req),
    .rd_rsp_o  (rd_rsp),
    .m_data_o  (m_data),
    .m_valid_o (m_valid),
    .m_ready_i (m_ready),
    .s_data_i  (s_data),
    .s_valid_i (s_valid),
    .s_ready_o (s_ready),
    .irq_o     (irq)
  );

  bind axil_mbox_top axil_mbox_asserts u_asserts (
    .clk       (clk),
    .arst      (arst),
    .wr_req_i  (wr_req_i),
    .wr_rsp_i  (wr_rsp_o),
    .rd_req_i  (rd_req_i),
    .rd_rsp_i  (rd_rsp_o),
    .m_data_i  (m_data_o),
    .m_valid_i (m_valid_o),
    .m_ready_i (m_ready_i)
  );

  always #4 clk = ~clk;  // 8 ns period.

  // ########################################
  // Random bits
  // ########################################
  function automatic logic rand_bit();
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);  // Maximal taps.
    return lfsr_q[0];
  endfunction

  function automatic mbox_pkg::mbox_word_t rand_word();
    mbox_pkg::mbox_word_t v;
    v = '0;
    for (int i = 0; i < `MBOX_DATA_W; i++) begin
      v = {v[`MBOX_DATA_W-2:0], rand_bit()};  // One step per bit.
    end
    return v;
  endfunction

  // ########################################
  // Compare tasks
  // ########################################
  task automatic check_word(input string name, input mbox_pkg::mbox_word_t exp,
                            input mbox_pkg::mbox_word_t act);
    checks++;
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected 0x%08h got 0x%08h", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_resp(input string name, input mbox_pkg::axil_resp_t exp,
                            input mbox_pkg::axil_resp_t act);
    checks++;
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_status(input string name, input mbox_pkg::mbox_status_t exp,
                              input mbox_pkg::mbox_status_t act);
    checks++;
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected 0x%02h got 0x%02h", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
      value_errors++;
    end
  endtask

  // ########################################
  // Bus and stream drivers
  // ########################################
  task automatic axil_write(input mbox_pkg::axil_addr_t addr, input mbox_pkg::mbox_word_t data,
                            output mbox_pkg::axil_resp_t resp);
    int cycles;
    resp = 2'b11;  // Marks a missing response.
    @(posedge clk);
    wr_req.awaddr  <= addr;
    wr_req.awvalid <= 1'b1;
    wr_req.wdata   <= data;
    wr_req.wvalid  <= 1'b1;
    cycles = 0;
    @(negedge clk);
    while (!wr_rsp.awready && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (wr_rsp.awready) begin
      check_flag("wready", 1'b1, wr_rsp.wready);  // Raised together with awready.
    end else begin
      $display("%0t write to 0x%0h was never accepted", $time, addr);
      other_errors++;
    end
    @(posedge clk);  // Acceptance edge.
    wr_req.awvalid <= 1'b0;
    wr_req.wvalid  <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (!wr_rsp.bvalid && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (wr_rsp.bvalid) begin
      resp = wr_rsp.bresp;
    end else begin
      $display("%0t write to 0x%0h got no response", $time, addr);
      other_errors++;
    end
    @(posedge clk);  // Response held while bready is low.
    wr_req.bready <= 1'b1;
    @(posedge clk);  // Response handshake edge.
    wr_req.bready <= 1'b0;
  endtask

  task automatic axil_read(input mbox_pkg::axil_addr_t addr, output mbox_pkg::mbox_word_t data,
                           output mbox_pkg::axil_resp_t resp);
    int cycles;
    resp = 2'b11;
    data = '0;
    @(posedge clk);
    rd_req.araddr  <= addr;
    rd_req.arvalid <= 1'b1;
    cycles = 0;
    @(negedge clk);
    while (!rd_rsp.arready && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!rd_rsp.arready) begin
      $display("%0t read of 0x%0h was never accepted", $time, addr);
      other_errors++;
    end
    @(posedge clk);  // Acceptance edge.
    rd_req.arvalid <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (!rd_rsp.rvalid && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (rd_rsp.rvalid) begin
      data = rd_rsp.rdata;
      resp = rd_rsp.rresp;
    end else begin
      $display("%0t read of 0x%0h got no response", $time, addr);
      other_errors++;
    end
    @(posedge clk);  // Response held while rready is low.
    rd_req.rready <= 1'b1;
    @(posedge clk);  // Response handshake edge.
    rd_req.rready <= 1'b0;
  endtask

  task automatic stream_send(input mbox_pkg::mbox_word_t word);
    int cycles;
    @(posedge clk);
    s_data  <= word;
    s_valid <= 1'b1;
    cycles = 0;
    @(negedge clk);
    while (!s_ready && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!s_ready) begin
      $display("%0t incoming stream word 0x%08h was never taken", $time, word);
      other_errors++;
    end
    @(posedge clk);  // Transfer edge.
    s_valid <= 1'b0;
  endtask

  task automatic stream_recv(output mbox_pkg::mbox_word_t word);
    int   cycles;
    logic got;
    got    = 1'b0;
    cycles = 0;
    word   = '0;
    while (!got && cycles < TIMEOUT) begin
      @(posedge clk);
      m_ready <= rand_bit();  // Random stall.
      @(negedge clk);
      if (m_valid && m_ready) begin
        word = m_data;
        got  = 1'b1;
      end
      cycles++;
    end
    if (!got) begin
      $display("%0t outgoing stream produced no word", $time);
      other_errors++;
    end
    @(posedge clk);
    m_ready <= 1'b0;
  endtask

  task automatic read_status(input string name, input mbox_pkg::mbox_status_t exp);
    mbox_pkg::mbox_word_t data;
    mbox_pkg::axil_resp_t resp;
    axil_read(`MBOX_REG_STATUS, data, resp);
    check_resp({name, " rresp"}, mbox_pkg::AXIL_OKAY, resp);
    check_word({name, " upper bits"}, '0, data >> STATUS_W);
    check_status(name, exp, mbox_pkg::mbox_status_t'(data[STATUS_W-1:0]));
  endtask

  // ########################################
  // Directed tests
  // ########################################
  task automatic after_reset();
    mbox_pkg::mbox_status_t exp;
    exp          = '0;
    exp.tx_empty = 1'b1;
    exp.rx_empty = 1'b1;
    read_status("status after reset", exp);
    check_flag("irq_o", 1'b0, irq);
  endtask

  task automatic tx_in_order();
    mbox_pkg::mbox_word_t   sent [4];
    mbox_pkg::mbox_word_t   got;
    mbox_pkg::axil_resp_t   resp;
    mbox_pkg::mbox_status_t exp;
    for (int i = 0; i < 4; i++) begin
      sent[i] = rand_word();
      axil_write(`MBOX_REG_TX, sent[i], resp);
      check_resp("tx bresp", mbox_pkg::AXIL_OKAY, resp);
    end
    for (int i = 0; i < 4; i++) begin
      stream_recv(got);
      check_word("m_data_o", sent[i], got);  // Same order as written.
    end
    exp          = '0;
    exp.tx_empty = 1'b1;
    exp.rx_empty = 1'b1;
    read_status("status after tx drain", exp);
  endtask

  task automatic rx_fill_and_drain();
    mbox_pkg::mbox_word_t   sent [4];
    mbox_pkg::mbox_word_t   got;
    mbox_pkg::axil_resp_t   resp;
    mbox_pkg::mbox_status_t exp;
    for (int i = 0; i < 4; i++) begin
      sent[i] = rand_word();
      stream_send(sent[i]);
    end
    @(negedge clk);
    check_flag("s_ready_o", 1'b0, s_ready);  // Receive queue is full.
    exp          = '0;
    exp.tx_empty = 1'b1;
    exp.rx_full  = 1'b1;
    read_status("status with rx full", exp);
    for (int i = 0; i < 4; i++) begin
      axil_read(`MBOX_REG_RX, got, resp);
      check_resp("rx rresp", mbox_pkg::AXIL_OKAY, resp);
      check_word("rx rdata", sent[i], got);
    end
  endtask

  task automatic tx_overflow_drop();
    mbox_pkg::mbox_word_t   sent [4];
    mbox_pkg::mbox_word_t   got;
    mbox_pkg::axil_resp_t   resp;
    mbox_pkg::mbox_status_t exp;
    for (int i = 0; i < 4; i++) begin
      sent[i] = rand_word();
      axil_write(`MBOX_REG_TX, sent[i], resp);
      check_resp("tx bresp", mbox_pkg::AXIL_OKAY, resp);
    end
    axil_write(`MBOX_REG_TX, rand_word(), resp);  // Fifth word into a full queue.
    check_resp("overflow bresp", mbox_pkg::AXIL_SLVERR, resp);
    exp             = '0;
    exp.tx_full     = 1'b1;
    exp.rx_empty    = 1'b1;
    exp.tx_overflow = 1'b1;
    read_status("status after overflow", exp);
    for (int i = 0; i < 4; i++) begin
      stream_recv(got);
      check_word("m_data_o", sent[i], got);
    end
    @(negedge clk);
    check_flag("m_valid_o", 1'b0, m_valid);  // Dropped word never shows.
    axil_write(`MBOX_REG_CTRL, 32'h2, resp);
    check_resp("clear bresp", mbox_pkg::AXIL_OKAY, resp);
    exp             = '0;
    exp.tx_empty    = 1'b1;
    exp.rx_empty    = 1'b1;
    read_status("status after clear", exp);
  endtask

  task automatic rx_underflow_read();
    mbox_pkg::mbox_word_t   got;
    mbox_pkg::axil_resp_t   resp;
    mbox_pkg::mbox_status_t exp;
    axil_read(`MBOX_REG_RX, got, resp);
    check_resp("underflow rresp", mbox_pkg::AXIL_SLVERR, resp);
    check_word("underflow rdata", '0, got);
    exp              = '0;
    exp.tx_empty     = 1'b1;
    exp.rx_empty     = 1'b1;
    exp.rx_underflow = 1'b1;
    read_status("status after underflow", exp);
    axil_write(`MBOX_REG_CTRL, 32'h2, resp);
    check_resp("clear bresp", mbox_pkg::AXIL_OKAY, resp);
  endtask

  task automatic irq_follows_rx();
    mbox_pkg::mbox_word_t word;
    mbox_pkg::mbox_word_t got;
    mbox_pkg::axil_resp_t resp;
    axil_write(`MBOX_REG_CTRL, 32'h1, resp);  // Enable on.
    check_resp("enable bresp", mbox_pkg::AXIL_OKAY, resp);
    axil_read(`MBOX_REG_CTRL, got, resp);
    check_word("ctrl readback", 32'h1, got);
    word = rand_word();
    stream_send(word);
    @(negedge clk);
    check_flag("irq_o with word", 1'b1, irq);
    axil_read(`MBOX_REG_RX, got, resp);
    check_word("irq rx rdata", word, got);
    @(negedge clk);
    check_flag("irq_o after read", 1'b0, irq);
    axil_write(`MBOX_REG_CTRL, 32'h0, resp);  // Enable off.
    word = rand_word();
    stream_send(word);
    @(negedge clk);
    check_flag("irq_o disabled", 1'b0, irq);
    axil_read(`MBOX_REG_RX, got, resp);
    check_word("disabled rx rdata", word, got);
  endtask

  initial begin
    clk          = 1'b0;
    arst         = 1'b1;
    wr_req       = '0;
    rd_req       = '0;
    m_ready      = 1'b0;
    s_data       = '0;
    s_valid      = 1'b0;
    lfsr_q       = 16'd52;
    value_errors = 0;
    other_errors = 0;
    checks       = 0;
    repeat (2) @(posedge clk);
    arst <= 1'b0;
    after_reset();
    tx_in_order();
    rx_fill_and_drain();
    tx_overflow_drop();
    rx_underflow_read();
    irq_follows_rx();
    $display("checks %0d, value errors %0d, other errors %0d", checks, value_errors,
             other_errors);
    if ((value_errors == 0) && (other_errors == 0)) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
